/* src/des_pkg.sv */
// DES package
// Block, key and round key types plus the DES tables and permutation functions
`default_nettype none

package des_pkg;

    localparam int NUM_ROUNDS = 16;

    // Bit 1 is the most significant bit, as in the standard
    typedef logic [1:64] des_block_t;
    typedef logic [1:32] des_half_t;
    typedef logic [1:64] des_key_t;
    typedef logic [1:48] des_subkey_t;
    typedef des_subkey_t [0:NUM_ROUNDS-1] des_subkeys_t;  // Entry 0 is round 1

    localparam int unsigned IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int unsigned FP_TAB [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam int unsigned E_TAB [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam int unsigned P_TAB [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    // Drops the parity bits, C half then D half
    localparam int unsigned PC1_TAB [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam int unsigned PC2_TAB [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
        26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    localparam int unsigned DES_SHIFTS [NUM_ROUNDS] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

    // Indexed by row * 16 + column
    localparam int unsigned SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    function automatic des_block_t des_ip(des_block_t b);
        des_block_t o;
        for (int i = 1; i <= 64; i++) o[i] = b[IP_TAB[i-1]];
        return o;
    endfunction

    function automatic des_block_t des_fp(des_block_t b);
        des_block_t o;
        for (int i = 1; i <= 64; i++) o[i] = b[FP_TAB[i-1]];
        return o;
    endfunction

    // Expansion, key mix, S-boxes and P
    function automatic des_half_t des_f(des_half_t r, des_subkey_t k);
        logic [1:48] x;
        logic [5:0]  six;
        logic [1:32] s_out;
        des_half_t   o;
        for (int i = 1; i <= 48; i++) x[i] = r[E_TAB[i-1]];
        x = x ^ k;
        for (int s = 0; s < 8; s++) begin
            six = x[6*s+1 +: 6];
            s_out[4*s+1 +: 4] = 4'(SBOX[s][{six[5], six[0], six[4:1]}]);  // Outer bits pick row
        end
        for (int i = 1; i <= 32; i++) o[i] = s_out[P_TAB[i-1]];
        return o;
    endfunction

    function automatic logic [1:56] des_pc1(des_key_t k);
        logic [1:56] o;
        for (int i = 1; i <= 56; i++) o[i] = k[PC1_TAB[i-1]];
        return o;
    endfunction

    function automatic des_subkey_t des_pc2(logic [1:56] cd);
        des_subkey_t o;
        for (int i = 1; i <= 48; i++) o[i] = cd[PC2_TAB[i-1]];
        return o;
    endfunction

endpackage

`default_nettype wire

/* src/des_in_stage.sv */
// DES input stage
// One-entry register taking plaintext blocks under valid/ready
`default_nettype none

module des_in_stage import des_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  des_block_t in_block,
    output logic       s_valid,
    input  logic       s_ready,
    output des_block_t s_block
);

    logic full;
    logic accept;

    assign in_ready = !full || s_ready;  // Refill in the same cycle the pipeline drains us
    assign accept   = in_valid && in_ready;
    assign s_valid  = full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (s_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s_block <= in_block;
        end
    end

endmodule

`default_nettype wire

/* src/des_key_schedule.sv */
// DES key schedule
// Stores the loaded key and derives the sixteen round keys from it combinationally
`default_nettype none

module des_key_schedule import des_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         key_load,
    input  des_key_t     key,
    output des_subkeys_t subkeys
);

    des_key_t key_q;

    // Left rotation of a 28-bit half by one or two places
    function automatic logic [1:28] rotl28(logic [1:28] v, int unsigned n);
        if (n == 2) begin
            return {v[3:28], v[1:2]};
        end
        return {v[2:28], v[1]};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_q <= '0;
        end else if (key_load) begin
            key_q <= key;  // New round keys follow on the next cycle
        end
    end

    always_comb begin : gen_keys
        logic [1:56] cd;
        logic [1:28] c_half;
        logic [1:28] d_half;
        cd     = des_pc1(key_q);
        c_half = cd[1:28];
        d_half = cd[29:56];
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            // Shifts accumulate from one round to the next
            c_half     = rotl28(c_half, DES_SHIFTS[r]);
            d_half     = rotl28(d_half, DES_SHIFTS[r]);
            subkeys[r] = des_pc2({c_half, d_half});
        end
    end

endmodule

`default_nettype wire

/* src/des_round.sv */
// DES Feistel round
// One pipeline stage with its own valid bit, moving only when advance is high
`default_nettype none

module des_round import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  logic        in_valid,
    input  des_half_t   l_in,
    input  des_half_t   r_in,
    input  des_subkey_t subkey,
    output logic        out_valid,
    output des_half_t   l_out,
    output des_half_t   r_out
);

    // Valid travels with the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            l_out <= r_in;
            r_out <= l_in ^ des_f(r_in, subkey);
        end
    end

endmodule

`default_nettype wire

/* src/des_pipeline.sv */
// DES round pipeline
// Initial permutation, sixteen registered rounds and the final permutation.
// All rounds stall together when the output side cannot take a block
`default_nettype none

module des_pipeline import des_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         s_valid,
    output logic         s_ready,
    input  des_block_t   s_block,
    input  des_subkeys_t subkeys,
    output logic         p_valid,
    input  logic         p_ready,
    output des_block_t   p_block
);

    des_block_t ip_block;
    logic       advance;

    // Stage 0 is the pipeline entry, stage 16 the last round
    logic       v_chain [0:NUM_ROUNDS];
    des_half_t  l_chain [0:NUM_ROUNDS];
    des_half_t  r_chain [0:NUM_ROUNDS];

    // A bubble in the last stage can always be overwritten
    assign advance = !v_chain[NUM_ROUNDS] || p_ready;
    assign s_ready = advance;

    assign ip_block   = des_ip(s_block);
    assign v_chain[0] = s_valid;
    assign l_chain[0] = ip_block[1:32];
    assign r_chain[0] = ip_block[33:64];

    genvar g;
    generate
        for (g = 0; g < NUM_ROUNDS; g++) begin : g_round
            des_round u_round (
                .clk       (clk),
                .rst_n     (rst_n),
                .advance   (advance),
                .in_valid  (v_chain[g]),
                .l_in      (l_chain[g]),
                .r_in      (r_chain[g]),
                .subkey    (subkeys[g]),  // Round g+1 key
                .out_valid (v_chain[g+1]),
                .l_out     (l_chain[g+1]),
                .r_out     (r_chain[g+1])
            );
        end
    endgenerate

    // Halves swap back after the last round
    assign p_valid = v_chain[NUM_ROUNDS];
    assign p_block = des_fp({r_chain[NUM_ROUNDS], l_chain[NUM_ROUNDS]});

endmodule

`default_nettype wire

/* src/des_out_queue.sv */
// DES output queue
// Circular FIFO holding ciphertext blocks until the consumer takes them
`default_nettype none

module des_out_queue import des_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       p_valid,
    output logic       p_ready,
    input  des_block_t p_block,
    output logic       out_valid,
    input  logic       out_ready,
    output des_block_t out_block
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
    localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

    des_block_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign p_ready   = count != FULL_CNT;
    assign out_valid = count != '0;
    assign out_block = mem[rd_ptr];  // Head entry stays put until read
    assign wr_en     = p_valid && p_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= p_block;
    end

endmodule

`default_nettype wire

/* src/des_core_top.sv */
// DES ECB encryption core
// Input stage, key schedule, sixteen-round pipeline and output queue
`default_nettype none

module des_core_top import des_pkg::*; #(
    parameter int OUT_DEPTH = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  des_block_t in_block,
    input  logic       key_load,
    input  des_key_t   key,
    output logic       out_valid,
    input  logic       out_ready,
    output des_block_t out_block
);

    logic         s_valid;
    logic         s_ready;
    des_block_t   s_block;
    logic         p_valid;
    logic         p_ready;
    des_block_t   p_block;
    des_subkeys_t subkeys;

    des_in_stage u_in_stage (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_block (in_block),
        .s_valid (s_valid), .s_ready (s_ready), .s_block (s_block)
    );

    des_key_schedule u_key_schedule (
        .clk (clk), .rst_n (rst_n),
        .key_load (key_load), .key (key), .subkeys (subkeys)
    );

    des_pipeline u_pipeline (
        .clk (clk), .rst_n (rst_n),
        .s_valid (s_valid), .s_ready (s_ready), .s_block (s_block),
        .subkeys (subkeys),
        .p_valid (p_valid), .p_ready (p_ready), .p_block (p_block)
    );

    des_out_queue #(.DEPTH(OUT_DEPTH)) u_out_queue (
        .clk (clk), .rst_n (rst_n),
        .p_valid (p_valid), .p_ready (p_ready), .p_block (p_block),
        .out_valid (out_valid), .out_ready (out_ready), .out_block (out_block)
    );

endmodule

`default_nettype wire

/* sim/des_checker.sv */
// DES result checker
// Watches the DUT ports, models DES from the package tables and compares each output
`default_nettype none

module des_checker import des_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       in_ready,
    input  des_block_t in_block,
    input  logic       key_load,
    input  des_key_t   key,
    input  logic       out_valid,
    input  logic       out_ready,
    input  des_block_t out_block,
    output int         error_count,
    output int         pending
);
    timeunit 1ns;
    timeprecision 1ps;

    des_key_t   model_key;
    des_block_t expected_q [$];
    des_block_t exp_block;
    des_block_t held_block;
    logic       held_valid;
    int         errs = 0;

    // Reference encryption, key schedule folded into the round loop
    function automatic des_block_t model_encrypt(des_key_t k, des_block_t pt);
        logic [1:56] cd;
        logic [1:28] c;
        logic [1:28] d;
        logic [1:48] sk;
        logic [1:48] x;
        logic [1:6]  six;
        logic [5:0]  idx;
        logic [1:32] sb_out;
        logic [1:32] f;
        logic [1:32] l;
        logic [1:32] r;
        logic [1:32] t;
        logic [1:64] b;
        des_block_t  ct;
        for (int i = 1; i <= 56; i++) cd[i] = k[PC1_TAB[i-1]];
        c = cd[1:28];
        d = cd[29:56];
        for (int i = 1; i <= 64; i++) b[i] = pt[IP_TAB[i-1]];
        l = b[1:32];
        r = b[33:64];
        for (int rnd = 0; rnd < NUM_ROUNDS; rnd++) begin
            for (int j = 0; j < DES_SHIFTS[rnd]; j++) begin
                c = {c[2:28], c[1]};
                d = {d[2:28], d[1]};
            end
            cd = {c, d};
            for (int i = 1; i <= 48; i++) sk[i] = cd[PC2_TAB[i-1]];
            for (int i = 1; i <= 48; i++) x[i] = r[E_TAB[i-1]] ^ sk[i];
            for (int s = 0; s < 8; s++) begin
                six = x[6*s+1 +: 6];
                idx = {six[1], six[6], six[2:5]};  // Outer bits give the row
                sb_out[4*s+1 +: 4] = 4'(SBOX[s][idx]);
            end
            for (int i = 1; i <= 32; i++) f[i] = sb_out[P_TAB[i-1]];
            t = r;
            r = l ^ f;
            l = t;
        end
        b = {r, l};  // No swap after round 16
        for (int i = 1; i <= 64; i++) ct[i] = b[FP_TAB[i-1]];
        return ct;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            model_key = '0;
            expected_q.delete();
            held_valid = 1'b0;
        end else begin
            // Stalled output must not move
            if (held_valid && !out_valid) begin
                errs++;
                $display("** Error at %0t ns: out_valid expected 1, got %b", $time, out_valid);
            end else if (held_valid && out_block !== held_block) begin
                errs++;
                $display("** Error at %0t ns: out_block expected %h, got %h",
                         $time, held_block, out_block);
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    errs++;
                    $display("Error at %0t ns: output block %h came out with none expected",
                             $time, out_block);
                end else begin
                    exp_block = expected_q.pop_front();
                    if (out_block !== exp_block) begin
                        errs++;
                        $display("** Error at %0t ns: out_block expected %h, got %h",
                                 $time, exp_block, out_block);
                    end
                end
            end
            if (key_load) model_key = key;  // Takes effect for a block accepted on this edge
            if (in_valid && in_ready) expected_q.push_back(model_encrypt(model_key, in_block));
            held_valid = out_valid && !out_ready;
            held_block = out_block;
        end
        error_count <= errs;
        pending     <= expected_q.size();
    end

endmodule

`default_nettype wire

/* sim/tb_des_top.sv */
// DES core testbench
// Known answer, random plaintext with gaps and back-pressure under two keys
`default_nettype none

module tb_des_top import des_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    des_block_t in_block;
    logic       key_load;
    des_key_t   key;
    logic       out_valid;
    logic       out_ready;
    des_block_t out_block;
    int         seed;
    int         tb_errors;
    int         checker_errors;
    int         checker_pending;

    always #10 clk = ~clk;

    des_core_top #(.OUT_DEPTH(2)) DUT (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_block (in_block),
        .key_load (key_load), .key (key),
        .out_valid (out_valid), .out_ready (out_ready), .out_block (out_block)
    );

    des_checker u_checker (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_block (in_block),
        .key_load (key_load), .key (key),
        .out_valid (out_valid), .out_ready (out_ready), .out_block (out_block),
        .error_count (checker_errors), .pending (checker_pending)
    );

    function automatic bit chance(int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    task automatic load_key(des_key_t k);
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
    endtask

    task automatic check_known_answer();
        int guard;
        bit done;
        guard    = 0;
        done     = 1'b0;
        in_valid <= 1'b1;
        in_block <= 64'h0123456789ABCDEF;
        out_ready <= 1'b1;
        while (!done && guard < 100) begin
            @(posedge clk);
            guard++;
            if (in_valid && in_ready) in_valid <= 1'b0;
            if (out_valid && out_ready) begin
                done = 1'b1;
                if (out_block !== 64'h85E813540F0AB405) begin
                    tb_errors++;
                    $display("** Error at %0t ns: out_block expected %h, got %h",
                             $time, 64'h85E813540F0AB405, out_block);
                end
            end
        end
        if (!done) begin
            tb_errors++;
            $display("Timeout: the known-answer block never came out");
        end
    endtask

    // Sends n blocks and collects n results, optionally checking latency and rate
    task automatic stream_blocks(int n, int gap_pct, int stall_pct, bit check_timing);
        int  sent;
        int  got;
        int  cycle;
        int  first_acc;
        int  last_out;
        bit  pending;
        sent = 0;
        got = 0;
        cycle = 0;
        first_acc = 0;
        last_out = 0;
        pending = 1'b0;
        while (got < n && cycle < n * 40 + 200) begin
            @(posedge clk);
            cycle++;
            if (in_valid && in_ready) begin
                if (sent == 0) first_acc = cycle;
                sent++;
                pending = 1'b0;
            end
            if (out_valid && out_ready) begin
                if (check_timing && got == 0 && cycle - first_acc != 18) begin
                    tb_errors++;
                    $display("** Error at %0t ns: out_valid latency expected 18, got %0d",
                             $time, cycle - first_acc);
                end else if (check_timing && got > 0 && cycle != last_out + 1) begin
                    tb_errors++;
                    $display("** Error at %0t ns: out_valid spacing expected 1, got %0d",
                             $time, cycle - last_out);
                end
                last_out = cycle;
                got++;
            end
            if (!pending) begin  // Hold block steady until taken
                if (sent < n && !chance(gap_pct)) begin
                    in_valid <= 1'b1;
                    in_block <= {$random(seed), $random(seed)};
                    pending  = 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= !chance(stall_pct);
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        if (got < n) begin
            tb_errors++;
            $display("Timeout: only %0d of %0d blocks came out", got, n);
        end
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while ((out_valid || !in_ready || checker_pending != 0) && guard < 100);
        if (out_valid || !in_ready || checker_pending != 0) begin
            tb_errors++;
            $display("Timeout: the engine did not drain to idle");
        end
    endtask

    task automatic finish_run();
        @(posedge clk);  // Checker counts from the last edge settle
        if (checker_pending != 0) begin
            tb_errors++;
            $display("Missing output: %0d blocks never came out", checker_pending);
        end
        $display("Error count: %0d from the checker, %0d from the testbench",
                 checker_errors, tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        seed      = 13;
        tb_errors = 0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_block  = '0;
        key_load  = 1'b0;
        key       = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            tb_errors++;
            $display("** Error at %0t ns: out_valid expected 0, got %b", $time, out_valid);
        end
        if (in_ready !== 1'b1) begin
            tb_errors++;
            $display("** Error at %0t ns: in_ready expected 1, got %b", $time, in_ready);
        end
        load_key(64'h133457799BBCDFF1);
        check_known_answer();
        stream_blocks(200, 30, 0, 1'b0);   // Gaps only
        wait_idle();
        stream_blocks(200, 20, 50, 1'b0);  // Random back-pressure
        wait_idle();
        stream_blocks(40, 0, 0, 1'b1);
        wait_idle();
        load_key({$random(seed), $random(seed)});
        stream_blocks(200, 25, 40, 1'b0);
        wait_idle();
        finish_run();
    end

endmodule

`default_nettype wire

/* src.f */
src/des_pkg.sv
src/des_in_stage.sv
src/des_key_schedule.sv
src/des_round.sv
src/des_pipeline.sv
src/des_out_queue.sv
src/des_core_top.sv
sim/des_checker.sv
sim/tb_des_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the DES testbench with Verilator, runs it and checks the log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_des_top \
    -f src.f -o sim_des > build.log 2>&1 \
    && ./obj_dir/sim_des > sim.log 2>&1 \
    || { echo "Build or run failed, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
